// File: design/branch_cond_if.sv
// --------------------------------------------------------------------------
// compare flags and jump target from the adder to the branch unit
// all signals are registered together with stage 0
// --------------------------------------------------------------------------

`timescale 1ns/1ps

interface branch_cond_if import exe_pkg::*; ();

    logic eq;
    logic carry;
    logic msb_c;
    logic sign;
    pc_t  jump_target;

    modport source (output eq, carry, msb_c, sign, jump_target);

    modport sink (input eq, carry, msb_c, sign, jump_target);

endinterface

// File: design/exe_adder.sv
// --------------------------------------------------------------------------
// one-cycle add/subtract with the flags needed for branch compares
// subtract uses rs2 only, so sub and imm_en must not be set together
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module exe_adder import exe_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          sub,
    input  logic          imm_en,
    input  rval_t         imm_val,
    input  rval_t         rs1_val,
    input  rval_t         rs2_val,
    output rval_t         rd_val,
    branch_cond_if.source cond
);

    logic [XLEN-1:0] operand;
    logic [XLEN:0]   sum;

    // subtract as rs1 + ~rs2 + 1
    always_comb begin
        operand = imm_en ? imm_val : rs2_val;
        if (sub) begin
            operand = ~operand;
        end
        sum = {1'b0, rs1_val} + {1'b0, operand} + {{XLEN{1'b0}}, sub};
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_val     <= '0;
            cond.carry <= 1'b0;
            cond.msb_c <= 1'b0;
            cond.sign  <= 1'b0;
            cond.eq    <= 1'b0;
        end else begin
            rd_val     <= rval_t'(sum[XLEN-1:0]);
            cond.carry <= sum[XLEN];
            // carry into the msb
            cond.msb_c <= sum[XLEN-1] ^ rs1_val[XLEN-1] ^ operand[XLEN-1];
            cond.sign  <= sum[XLEN-1];
            cond.eq    <= (rs1_val == rs2_val);
        end
    end

    assign cond.jump_target = pc_t'({rd_val[XLEN-1:1], 1'b0});

    a_sub_no_imm: assert property (@(posedge clk) disable iff (reset) !(sub && imm_en));

endmodule

// File: design/exe_branch.sv
// --------------------------------------------------------------------------
// branch decision on the stage-0 instruction and the per-thread phase table
// a branch whose phase is stale never fires
// branch outputs and the phase flip appear one cycle after stage 0
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module exe_branch import exe_pkg::*; (
    input  logic                 clk,
    input  logic                 reset,
    input  id_t                  id,
    input  phase_t               phase,
    input  branch_mode_t         mode,
    input  pc_t                  imm_pc,
    input  logic                 valid,
    branch_cond_if.sink          cond,
    output phase_t [THREADS-1:0] phase_table,
    output id_t                  branch_id,
    output pc_t                  branch_pc,
    output logic                 branch_valid
);

    logic overflow;
    logic lt;
    logic ltu;
    logic cond_true;
    logic taken;

    always_comb begin
        overflow = cond.carry ^ cond.msb_c;
        lt       = cond.sign ^ overflow;
        ltu      = !cond.carry;
        case (mode)
            BR_BEQ:  cond_true = cond.eq;
            BR_BNE:  cond_true = !cond.eq;
            BR_JAL:  cond_true = 1'b1;
            BR_JALR: cond_true = 1'b1;
            BR_BLT:  cond_true = lt;
            BR_BGE:  cond_true = !lt;
            BR_BLTU: cond_true = ltu;
            BR_BGEU: cond_true = !ltu;
        endcase
        taken = valid && (phase == phase_table[id]) && cond_true;
    end

    // ----------------------------------------------------------------------
    // phase table and branch strobe
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            phase_table  <= '0;
            branch_valid <= 1'b0;
        end else begin
            branch_valid <= taken;
            if (taken) begin
                phase_table[id] <= ~phase_table[id];
            end
        end
    end

    // jalr takes its target from the adder
    always_ff @(posedge clk) begin
        if (taken) begin
            branch_id <= id;
            branch_pc <= (mode == BR_JALR) ? cond.jump_target : imm_pc;
        end
    end

    a_pc_known: assert property (@(posedge clk) disable iff (reset)
        branch_valid |-> !$isunknown(branch_pc));

endmodule

// File: design/exe_logical.sv
// --------------------------------------------------------------------------
// one-cycle AND/OR/XOR unit
// mode 3 gives a zero result
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module exe_logical import exe_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic_mode_t mode,
    input  logic        imm_en,
    input  rval_t       imm_val,
    input  rval_t       rs1_val,
    input  rval_t       rs2_val,
    output rval_t       rd_val
);

    rval_t operand;
    rval_t result;

    always_comb begin
        operand = imm_en ? imm_val : rs2_val;
        case (mode)
            LOGIC_AND: result = rs1_val & operand;
            LOGIC_OR:  result = rs1_val | operand;
            LOGIC_XOR: result = rs1_val ^ operand;
            default:   result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_val <= '0;
        end else begin
            rd_val <= result;
        end
    end

endmodule

// File: design/exe_pipeline.sv
// --------------------------------------------------------------------------
// execution stage of a multi-threaded RV32I core, no stalls
// one decoded instruction may issue every cycle on s_valid
// writeback 3 cycles after issue, branch strobe 2 cycles after issue
// stale-phase instructions are squashed when entering stage 1
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module exe_pipeline import exe_pkg::*; (
    input  logic         clk,
    input  logic         reset,
    input  logic         s_valid,
    input  id_t          s_id,
    input  phase_t       s_phase,
    input  logic         s_rd_en,
    input  ridx_t        s_rd_idx,
    input  rval_t        s_rd_val,
    input  rval_t        s_rs1_val,
    input  rval_t        s_rs2_val,
    input  logic         s_adder,
    input  logic         s_logical,
    input  logic         s_shifter,
    input  logic         s_branch,
    input  logic         s_adder_sub,
    input  logic         s_adder_imm_en,
    input  rval_t        s_adder_imm_val,
    input  logic_mode_t  s_logical_mode,
    input  logic         s_logical_imm_en,
    input  rval_t        s_logical_imm_val,
    input  logic         s_shifter_arithmetic,
    input  logic         s_shifter_left,
    input  logic         s_shifter_imm_en,
    input  shamt_t       s_shifter_imm_val,
    input  branch_mode_t s_branch_mode,
    input  pc_t          s_branch_pc,
    output id_t          branch_id,
    output pc_t          branch_pc,
    output logic         branch_valid,
    output logic         wb_valid,
    output id_t          wb_id,
    output logic         wb_rd_en,
    output ridx_t        wb_rd_idx,
    output rval_t        wb_rd_val
);

    rval_t                adder_rd_val;
    rval_t                logical_rd_val;
    rval_t                shifter_rd_val;
    phase_t [THREADS-1:0] phase_table;

    logic         st0_valid;
    logic         st0_rd_en;
    logic         st0_branch;
    logic         st0_keep;
    id_t          st0_id;
    phase_t       st0_phase;
    ridx_t        st0_rd_idx;
    rval_t        st0_rd_val;
    logic         st0_adder;
    logic         st0_logical;
    logic         st0_shifter;
    branch_mode_t st0_branch_mode;
    pc_t          st0_branch_pc;

    logic         st1_valid;
    logic         st1_rd_en;
    id_t          st1_id;
    ridx_t        st1_rd_idx;
    rval_t        st1_rd_val;
    logic         st1_shifter;
    rval_t        st1_shift_val;

    branch_cond_if i_cond ();

    exe_adder i_exe_adder (
        .clk     (clk),
        .reset   (reset),
        .sub     (s_adder_sub),
        .imm_en  (s_adder_imm_en),
        .imm_val (s_adder_imm_val),
        .rs1_val (s_rs1_val),
        .rs2_val (s_rs2_val),
        .rd_val  (adder_rd_val),
        .cond    (i_cond)
    );

    exe_logical i_exe_logical (
        .clk     (clk),
        .reset   (reset),
        .mode    (s_logical_mode),
        .imm_en  (s_logical_imm_en),
        .imm_val (s_logical_imm_val),
        .rs1_val (s_rs1_val),
        .rs2_val (s_rs2_val),
        .rd_val  (logical_rd_val)
    );

    exe_shifter i_exe_shifter (
        .clk        (clk),
        .reset      (reset),
        .arithmetic (s_shifter_arithmetic),
        .left       (s_shifter_left),
        .imm_en     (s_shifter_imm_en),
        .imm_val    (s_shifter_imm_val),
        .rs1_val    (s_rs1_val),
        .rs2_val    (s_rs2_val),
        .rd_val     (shifter_rd_val)
    );

    exe_branch i_exe_branch (
        .clk          (clk),
        .reset        (reset),
        .id           (st0_id),
        .phase        (st0_phase),
        .mode         (st0_branch_mode),
        .imm_pc       (st0_branch_pc),
        .valid        (st0_branch),
        .cond         (i_cond),
        .phase_table  (phase_table),
        .branch_id    (branch_id),
        .branch_pc    (branch_pc),
        .branch_valid (branch_valid)
    );

    // stale phase means a taken branch of this thread went ahead
    assign st0_keep = (phase_table[st0_id] == st0_phase);

    // ----------------------------------------------------------------------
    // stage valids and write enables
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid  <= 1'b0;
            st0_rd_en  <= 1'b0;
            st0_branch <= 1'b0;
            st1_valid  <= 1'b0;
            st1_rd_en  <= 1'b0;
            wb_valid   <= 1'b0;
            wb_rd_en   <= 1'b0;
        end else begin
            st0_valid  <= s_valid;
            st0_rd_en  <= s_rd_en & s_valid;
            st0_branch <= s_branch & s_valid;
            st1_valid  <= st0_valid & st0_keep;
            st1_rd_en  <= st0_rd_en & st0_keep;
            wb_valid   <= st1_valid;
            wb_rd_en   <= st1_rd_en;
        end
    end

    // ----------------------------------------------------------------------
    // stage payload
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        st0_id          <= s_id;
        st0_phase       <= s_phase;
        st0_rd_idx      <= s_rd_idx;
        st0_rd_val      <= s_rd_val;
        st0_adder       <= s_adder;
        st0_logical     <= s_logical;
        st0_shifter     <= s_shifter;
        st0_branch_mode <= s_branch_mode;
        st0_branch_pc   <= s_branch_pc;

        // link value passes through unless a unit result is picked
        st1_id        <= st0_id;
        st1_rd_idx    <= st0_rd_idx;
        st1_rd_val    <= st0_adder   ? adder_rd_val   :
                         st0_logical ? logical_rd_val :
                         st0_rd_val;
        st1_shifter   <= st0_shifter;
        st1_shift_val <= shifter_rd_val;

        wb_id     <= st1_id;
        wb_rd_idx <= st1_rd_idx;
        wb_rd_val <= st1_shifter ? st1_shift_val : st1_rd_val;
    end

    a_wb_en_valid: assert property (@(posedge clk) disable iff (reset) wb_rd_en |-> wb_valid);

endmodule

// File: design/exe_pkg.sv
// --------------------------------------------------------------------------
// widths, types and op codes shared by the execution stage
// THREADS must be a power of two and at least 2
// PC_BITS and XLEN are expected to match (jalr target comes from the adder)
// --------------------------------------------------------------------------

package exe_pkg;

    localparam int XLEN       = 32;
    localparam int THREADS    = 4;
    localparam int ID_BITS    = $clog2(THREADS);
    localparam int SHAMT_BITS = $clog2(XLEN);
    localparam int PC_BITS    = 32;

    typedef logic [ID_BITS-1:0]     id_t;
    typedef logic                   phase_t;
    typedef logic [PC_BITS-1:0]     pc_t;
    typedef logic [4:0]             ridx_t;
    typedef logic signed [XLEN-1:0] rval_t;
    typedef logic [SHAMT_BITS-1:0]  shamt_t;
    typedef logic [1:0]             logic_mode_t;
    typedef logic [2:0]             branch_mode_t;

    // logical unit ops (code 3 yields zero)
    localparam logic_mode_t LOGIC_AND = 2'd0;
    localparam logic_mode_t LOGIC_OR  = 2'd1;
    localparam logic_mode_t LOGIC_XOR = 2'd2;

    // branch modes
    localparam branch_mode_t BR_BEQ  = 3'b000;
    localparam branch_mode_t BR_BNE  = 3'b001;
    localparam branch_mode_t BR_JAL  = 3'b010;
    localparam branch_mode_t BR_JALR = 3'b011;
    localparam branch_mode_t BR_BLT  = 3'b100;
    localparam branch_mode_t BR_BGE  = 3'b101;
    localparam branch_mode_t BR_BLTU = 3'b110;
    localparam branch_mode_t BR_BGEU = 3'b111;

endpackage

// File: design/exe_shifter.sv
// --------------------------------------------------------------------------
// one-cycle barrel shifter on the issue-side operands
// only the low SHAMT_BITS of rs2 count as the amount
// left and arithmetic must not be set together
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module exe_shifter import exe_pkg::*; (
    input  logic   clk,
    input  logic   reset,
    input  logic   arithmetic,
    input  logic   left,
    input  logic   imm_en,
    input  shamt_t imm_val,
    input  rval_t  rs1_val,
    input  rval_t  rs2_val,
    output rval_t  rd_val
);

    shamt_t shamt;
    rval_t  result;

    always_comb begin
        shamt = imm_en ? imm_val : shamt_t'(rs2_val[SHAMT_BITS-1:0]);
        if (left) begin
            result = rs1_val << shamt;
        end else if (arithmetic) begin
            // rval_t is signed so this keeps the sign
            result = rs1_val >>> shamt;
        end else begin
            result = rs1_val >> shamt;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_val <= '0;
        end else begin
            rd_val <= result;
        end
    end

    a_no_arith_left: assert property (@(posedge clk) disable iff (reset) !(left && arithmetic));

endmodule

// File: flist.f
design/exe_pkg.sv
design/branch_cond_if.sv
design/exe_adder.sv
design/exe_logical.sv
design/exe_shifter.sv
design/exe_branch.sv
design/exe_pipeline.sv
testbench/tb_clock_gen.sv
testbench/tb_exe_pipeline.sv

// File: testbench/exe_stimulus.mem
// ctl(valid,id,phase,unit,op,rd_en,rd_idx) rs1 rs2 imm link br_pc expect wb_val br_target
// unit 1 add 2 logic 3 shift 4 branch; expect bit 8 branch, bit 4 rd_en, bit 0 writeback
00040100 00000000 00000000 00000000 00000000 00000000 000 00000000 00000000
00000000 00000000 00000000 00000000 00000000 00000000 000 00000000 00000000
10010105 7FFFFFFF 00000001 00000000 00000000 00000000 011 80000000 00000000
10011106 00000003 00000005 00000000 00000000 00000000 011 FFFFFFFE 00000000
10012107 FFFFFFFF 12345678 00000002 00000000 00000000 011 00000001 00000000
10020108 F0F0FF00 0FF0F0F0 00000000 00000000 00000000 011 00F0F000 00000000
10021109 F0F0FF00 0FF0F0F0 00000000 00000000 00000000 011 FFF0FFF0 00000000
1002210A F0F0FF00 0FF0F0F0 00000000 00000000 00000000 011 FF000FF0 00000000
1002410B 12345678 FFFFFFFF 0000FFFF 00000000 00000000 011 00005678 00000000
1002510C 12340000 FFFFFFFF 00005678 00000000 00000000 011 12345678 00000000
1002610D AAAAAAAA 00000000 FFFFFFFF 00000000 00000000 011 55555555 00000000
1003210E F0000001 00000024 00000000 00000000 00000000 011 00000010 00000000
1003010F F0000000 FFFFFFE4 00000000 00000000 00000000 011 0F000000 00000000
10031110 F0000000 00000044 00000000 00000000 00000000 011 FF000000 00000000
10035111 80000000 00000000 0000001F 00000000 00000000 011 FFFFFFFF 00000000
10010010 00000001 00000002 00000000 00000000 00000000 001 00000000 00000000
13040000 00000005 00000005 00000000 00000000 00001000 101 00000000 00001000
13140000 00000005 00000006 00000000 00000000 00001004 001 00000000 00000000
13141000 00000005 00000006 00000000 00000000 00001008 101 00000000 00001008
13041000 00000007 00000007 00000000 00000000 0000100C 001 00000000 00000000
13044000 FFFFFFFF 00000001 00000000 00000000 00001010 101 00000000 00001010
13144000 00000002 00000002 00000000 00000000 00001014 001 00000000 00000000
13145000 00000001 FFFFFFFF 00000000 00000000 00001018 101 00000000 00001018
13045000 80000000 7FFFFFFF 00000000 00000000 0000101C 001 00000000 00000000
13046000 00000001 FFFFFFFF 00000000 00000000 00001020 101 00000000 00001020
13146000 FFFFFFFF 00000001 00000000 00000000 00001024 001 00000000 00000000
13147000 FFFFFFFF 00000001 00000000 00000000 00001028 101 00000000 00001028
13047000 00000001 80000000 00000000 00000000 0000102C 001 00000000 00000000
1304210A 00000000 00000000 00000000 00002004 00002000 111 00002004 00002000
1314310B 00003001 00000000 00000004 00002008 00005550 111 00002008 00003004
11040000 00000000 00000000 00000000 00000000 00004000 101 00000000 00004000
1101010C 00000001 00000001 00000000 00000000 00000000 000 00000000 00000000
1201010D 00000010 00000020 00000000 00000000 00000000 011 00000030 00000000
1101010E 00000001 00000002 00000000 00000000 00000000 000 00000000 00000000
1111010F 00000100 00000023 00000000 00000000 00000000 011 00000123 00000000
00000000 00000000 00000000 00000000 00000000 00000000 000 00000000 00000000

// File: testbench/tb_clock_gen.sv
// --------------------------------------------------------------------------
// free-running testbench clock, starts low
// PERIOD_NS should be even so both half periods are equal
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// File: testbench/tb_exe_pipeline.sv
// --------------------------------------------------------------------------
// testbench for the execution stage
// run from the project root
// vectors come from testbench/exe_stimulus.mem with one issue per cycle
// expected strobes are matched to the exact cycle they are due in
// --------------------------------------------------------------------------

`timescale 1ns/1ps

module tb_exe_pipeline import exe_pkg::*; ();

    localparam int WORDS   = 9;
    localparam int MAX_VEC = 64;
    localparam int TIMEOUT = 20;

    typedef struct packed {
        int    due;
        int    vec;
        id_t   id;
        logic  rd_en;
        ridx_t rd_idx;
        rval_t rd_val;
    } wb_exp_t;

    typedef struct packed {
        int  due;
        int  vec;
        id_t id;
        pc_t pc;
    } br_exp_t;

    logic         clk;
    logic         reset;
    logic         s_valid;
    id_t          s_id;
    phase_t       s_phase;
    logic         s_rd_en;
    ridx_t        s_rd_idx;
    rval_t        s_rd_val;
    rval_t        s_rs1_val;
    rval_t        s_rs2_val;
    logic         s_adder;
    logic         s_logical;
    logic         s_shifter;
    logic         s_branch;
    logic         s_adder_sub;
    logic         s_adder_imm_en;
    rval_t        s_adder_imm_val;
    logic_mode_t  s_logical_mode;
    logic         s_logical_imm_en;
    rval_t        s_logical_imm_val;
    logic         s_shifter_arithmetic;
    logic         s_shifter_left;
    logic         s_shifter_imm_en;
    shamt_t       s_shifter_imm_val;
    branch_mode_t s_branch_mode;
    pc_t          s_branch_pc;
    id_t          branch_id;
    pc_t          branch_pc;
    logic         branch_valid;
    logic         wb_valid;
    id_t          wb_id;
    logic         wb_rd_en;
    ridx_t        wb_rd_idx;
    rval_t        wb_rd_val;

    logic [31:0] vec_mem [0:WORDS*MAX_VEC-1];
    wb_exp_t     wb_q[$];
    br_exp_t     br_q[$];
    int          cycle = 0;
    int          value_errors = 0;
    int          protocol_errors = 0;

    tb_clock_gen #(.PERIOD_NS(8)) i_tb_clock_gen (.clk(clk));

    exe_pipeline i_exe_pipeline (.*);

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------------------------------------
    // compare tasks
    // ----------------------------------------------------------------------

    task automatic check_rval(input string name, input rval_t exp, input rval_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_pc(input string name, input pc_t exp, input pc_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_id(input string name, input id_t exp, input id_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_ridx(input string name, input ridx_t exp, input ridx_t act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("[ERROR] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    task automatic init_inputs();
        s_valid              = 1'b0;
        s_id                 = '0;
        s_phase              = 1'b0;
        s_rd_en              = 1'b0;
        s_rd_idx             = '0;
        s_rd_val             = '0;
        s_rs1_val            = '0;
        s_rs2_val            = '0;
        s_adder              = 1'b0;
        s_logical            = 1'b0;
        s_shifter            = 1'b0;
        s_branch             = 1'b0;
        s_adder_sub          = 1'b0;
        s_adder_imm_en       = 1'b0;
        s_adder_imm_val      = '0;
        s_logical_mode       = '0;
        s_logical_imm_en     = 1'b0;
        s_logical_imm_val    = '0;
        s_shifter_arithmetic = 1'b0;
        s_shifter_left       = 1'b0;
        s_shifter_imm_en     = 1'b0;
        s_shifter_imm_val    = '0;
        s_branch_mode        = '0;
        s_branch_pc          = '0;
    endtask

    task automatic drive_vector(input int v);
        logic [31:0] ctl;
        logic [31:0] imm;
        logic [31:0] expect_flags;
        logic [3:0]  unit;
        logic [3:0]  op;
        wb_exp_t     wb_e;
        br_exp_t     br_e;
        ctl          = vec_mem[v*WORDS];
        imm          = vec_mem[v*WORDS+3];
        expect_flags = vec_mem[v*WORDS+6];
        unit         = ctl[19:16];
        op           = ctl[15:12];
        s_valid      = ctl[28];
        s_id         = id_t'(ctl[27:24]);
        s_phase      = ctl[20];
        s_rd_en      = ctl[8];
        s_rd_idx     = ridx_t'(ctl[4:0]);
        s_rs1_val    = vec_mem[v*WORDS+1];
        s_rs2_val    = vec_mem[v*WORDS+2];
        s_rd_val     = vec_mem[v*WORDS+4];
        s_branch_pc  = vec_mem[v*WORDS+5];
        s_adder      = (unit == 4'd1);
        s_logical    = (unit == 4'd2);
        s_shifter    = (unit == 4'd3);
        s_branch     = (unit == 4'd4);
        // conditional branches compare by subtracting and jalr adds the immediate
        if (s_branch) begin
            s_adder_sub    = (op != 4'd2) && (op != 4'd3);
            s_adder_imm_en = (op == 4'd3);
        end else begin
            s_adder_sub    = s_adder && op[0];
            s_adder_imm_en = s_adder && op[1];
        end
        s_adder_imm_val      = imm;
        s_logical_mode       = s_logical ? op[1:0] : 2'd0;
        s_logical_imm_en     = s_logical && op[2];
        s_logical_imm_val    = imm;
        s_shifter_arithmetic = s_shifter && op[0];
        s_shifter_left       = s_shifter && op[1];
        s_shifter_imm_en     = s_shifter && op[2];
        s_shifter_imm_val    = shamt_t'(imm[4:0]);
        s_branch_mode        = branch_mode_t'(op[2:0]);
        if (s_valid && expect_flags[0]) begin
            wb_e.due    = cycle + 3;
            wb_e.vec    = v;
            wb_e.id     = s_id;
            wb_e.rd_en  = expect_flags[4];
            wb_e.rd_idx = s_rd_idx;
            wb_e.rd_val = vec_mem[v*WORDS+7];
            wb_q.push_back(wb_e);
        end
        if (s_valid && expect_flags[8]) begin
            br_e.due = cycle + 2;
            br_e.vec = v;
            br_e.id  = s_id;
            br_e.pc  = vec_mem[v*WORDS+8];
            br_q.push_back(br_e);
        end
    endtask

    // ----------------------------------------------------------------------
    // scoreboard
    // ----------------------------------------------------------------------

    task automatic match_writeback();
        wb_exp_t e;
        string   name;
        if (wb_q.size() > 0 && wb_q[0].due < cycle) begin
            e = wb_q.pop_front();
            protocol_errors++;
            $display("vector %0d: no writeback in cycle %0d", e.vec, e.due);
        end
        if ($isunknown(wb_valid)) begin
            protocol_errors++;
            $display("wb_valid is unknown in cycle %0d", cycle);
        end else if (wb_valid) begin
            if (wb_q.size() == 0 || wb_q[0].due != cycle) begin
                protocol_errors++;
                $display("unexpected writeback of thread %0d in cycle %0d", wb_id, cycle);
            end else begin
                e    = wb_q.pop_front();
                name = $sformatf("vector %0d", e.vec);
                check_id({name, " wb_id"}, e.id, wb_id);
                check_bit({name, " wb_rd_en"}, e.rd_en, wb_rd_en);
                if (e.rd_en) begin
                    check_ridx({name, " wb_rd_idx"}, e.rd_idx, wb_rd_idx);
                    check_rval({name, " wb_rd_val"}, e.rd_val, wb_rd_val);
                end
            end
        end
    endtask

    task automatic match_branch();
        br_exp_t e;
        string   name;
        if (br_q.size() > 0 && br_q[0].due < cycle) begin
            e = br_q.pop_front();
            protocol_errors++;
            $display("vector %0d: branch not taken in cycle %0d", e.vec, e.due);
        end
        if ($isunknown(branch_valid)) begin
            protocol_errors++;
            $display("branch_valid is unknown in cycle %0d", cycle);
        end else if (branch_valid) begin
            if (br_q.size() == 0 || br_q[0].due != cycle) begin
                protocol_errors++;
                $display("unexpected branch to %h in cycle %0d", branch_pc, cycle);
            end else begin
                e    = br_q.pop_front();
                name = $sformatf("vector %0d", e.vec);
                check_id({name, " branch_id"}, e.id, branch_id);
                check_pc({name, " branch_pc"}, e.pc, branch_pc);
            end
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            match_writeback();
            match_branch();
        end
    end

    task automatic wait_for_drain();
        int n;
        n = 0;
        while ((wb_q.size() != 0 || br_q.size() != 0) && n < TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (wb_q.size() != 0 || br_q.size() != 0) begin
            protocol_errors++;
            $display("timeout: %0d writebacks and %0d branches still missing after %0d cycles",
                     wb_q.size(), br_q.size(), TIMEOUT);
        end
    endtask

    // ----------------------------------------------------------------------
    // main sequence
    // ----------------------------------------------------------------------

    initial begin
        int n_vec;
        init_inputs();
        reset = 1'b1;
        $readmemh("testbench/exe_stimulus.mem", vec_mem);
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        n_vec = 0;
        while (n_vec < MAX_VEC && !$isunknown(vec_mem[n_vec*WORDS])) begin
            n_vec++;
        end
        if (n_vec == 0) begin
            protocol_errors++;
            $display("no vectors found in the stimulus file");
        end
        for (int v = 0; v < n_vec; v++) begin
            @(posedge clk);
            #1;
            drive_vector(v);
        end
        @(posedge clk);
        #1;
        init_inputs();
        wait_for_drain();
        // idle window over the pipeline depth
        // late strobes would show up here
        repeat (4) @(posedge clk);
        $display("errors: %0d value mismatches, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
